//--- flow_table_params.svh
`ifndef FLOW_TABLE_PARAMS_SVH
`define FLOW_TABLE_PARAMS_SVH

// index bits of one hash bank
`define FT_DEPTH_NBITS 4
// bucket width, same as the host data word
`define FT_BUCKET_NBITS 32

// flow id width, 16 flows
`define FT_VALUE_DEPTH_NBITS 4
`define FT_KEY_NBITS 48
`define FT_ETIME_NBITS 16

// new-flow queue entries, also the sender's starting credit
`define FT_FIFO_DEPTH 4

`endif

//--- flow_table_pkg.sv
`default_nettype none

`include "flow_table_params.svh"

package flow_table_pkg;

    // flow id indexes the key and expiry memories
    typedef logic [`FT_VALUE_DEPTH_NBITS-1:0] fid_t;
    typedef logic [`FT_ETIME_NBITS-1:0] etime_t;
    typedef logic [`FT_KEY_NBITS-1:0] flow_key_t;

    // hash bucket, doubles as the host register word
    typedef logic [`FT_BUCKET_NBITS-1:0] bucket_t;
    typedef logic [`FT_DEPTH_NBITS-1:0] bank_addr_t;

    // clear after reset, then normal operation
    typedef enum logic {
        CLEAR = 1'b0,
        RUN   = 1'b1
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- etime_upd_if.sv
`timescale 1ns/10ps
`default_nettype none

interface etime_upd_if;
    import flow_table_pkg::*;

    // queue holds at least one entry
    logic valid;
    fid_t fid;
    etime_t etime;
    // head consumed in this cycle
    logic take;

    modport src (
        output valid,
        output fid,
        output etime,
        input  take
    );

    modport snk (
        input  valid,
        input  fid,
        input  etime,
        output take
    );

endinterface

`default_nettype wire

//--- ram_1r1w.sv
`timescale 1ns/10ps
`default_nettype none

module ram_1r1w #(
    parameter int WIDTH       = 32,
    parameter int DEPTH_NBITS = 4
) (
    input  wire logic                   clk,
    input  wire logic                   wr,
    input  wire logic [DEPTH_NBITS-1:0] waddr,
    input  wire logic [WIDTH-1:0]       din,
    input  wire logic [DEPTH_NBITS-1:0] raddr,
    output logic      [WIDTH-1:0]       dout
);

    logic [WIDTH-1:0] mem [2**DEPTH_NBITS];

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[waddr] <= din;
        end
        dout <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- init_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module init_ctrl (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic sweep_last,
    output logic      clear_en,
    output logic      upd_en,
    output logic      ready
);
    import flow_table_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            CLEAR: begin
                // last sweep address written this cycle
                if (sweep_last) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                state_nxt = RUN;
            end
            default: begin
                state_nxt = CLEAR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= CLEAR;
            clear_en <= 1'b1;
            upd_en <= 1'b0;
        end else begin
            state <= state_nxt;
            clear_en <= (state_nxt == CLEAR);
            upd_en <= (state_nxt == RUN);
        end
    end

    assign ready = upd_en;

    // sweep writes and normal writes share the memory write ports
    assert property (@(posedge clk) disable iff (reset) !(clear_en && upd_en));

endmodule

`default_nettype wire

//--- sweep_counter.sv
`timescale 1ns/10ps
`default_nettype none

module sweep_counter (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           clear_en,
    output flow_table_pkg::fid_t sweep_addr,
    output logic                sweep_last
);

    // walks every flow id once, wraps to zero after the last
    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_addr <= '0;
        end else if (clear_en) begin
            sweep_addr <= sweep_addr + 1'b1;
        end
    end

    assign sweep_last = clear_en && (sweep_addr == '1);

endmodule

`default_nettype wire

//--- etime_upd_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "flow_table_params.svh"

module etime_upd_fifo (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   push,
    input  wire flow_table_pkg::fid_t   push_fid,
    input  wire flow_table_pkg::etime_t push_etime,
    output logic                        credit,
    etime_upd_if.src                    upd
);
    import flow_table_pkg::*;

    localparam int PTR_NBITS = $clog2(`FT_FIFO_DEPTH);
    localparam int CNT_NBITS = $clog2(`FT_FIFO_DEPTH + 1);

    fid_t fid_q [`FT_FIFO_DEPTH];
    etime_t etime_q [`FT_FIFO_DEPTH];

    logic [PTR_NBITS-1:0] wr_ptr;
    logic [PTR_NBITS-1:0] rd_ptr;
    logic [CNT_NBITS-1:0] count;
    logic full;
    logic pop;

    function automatic logic [PTR_NBITS-1:0] next_ptr(input logic [PTR_NBITS-1:0] ptr);
        if (ptr == PTR_NBITS'(`FT_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == CNT_NBITS'(`FT_FIFO_DEPTH));
    assign pop = upd.take;

    // head presented without a read latency
    assign upd.valid = (count != '0);
    assign upd.fid = fid_q[rd_ptr];
    assign upd.etime = etime_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fid_q[wr_ptr] <= push_fid;
            etime_q[wr_ptr] <= push_etime;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_NBITS'(push) - CNT_NBITS'(pop);
            // one credit back per entry taken, a cycle later
            credit <= pop;
        end
    end

    // sender only pushes while it holds a credit
    assert property (@(posedge clk) disable iff (reset) !(push && full));

    // the value memory only takes a head that is there
    assert property (@(posedge clk) disable iff (reset) upd.take |-> upd.valid);

endmodule

`default_nettype wire

//--- flow_value_mem.sv
`timescale 1ns/10ps
`default_nettype none

module flow_value_mem (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      clear_en,
    input  wire logic                      upd_en,
    input  wire flow_table_pkg::fid_t      sweep_addr,
    input  wire flow_table_pkg::etime_t    current_time,
    input  wire logic                      hit_valid,
    input  wire flow_table_pkg::fid_t      hit_fid,
    input  wire logic                      key_rd,
    input  wire flow_table_pkg::fid_t      key_raddr,
    input  wire logic                      key_wr,
    input  wire flow_table_pkg::fid_t      key_waddr,
    input  wire flow_table_pkg::flow_key_t key_wdata,
    output logic                           key_ack,
    output flow_table_pkg::flow_key_t      key_rdata,
    input  wire logic                      etime_rd,
    input  wire flow_table_pkg::fid_t      etime_raddr,
    output logic                           etime_ack,
    output flow_table_pkg::etime_t         etime_rdata,
    etime_upd_if.snk                       upd
);
    import flow_table_pkg::*;

    logic hit_valid_d1;
    fid_t hit_fid_d1;
    etime_t hit_time_d1;

    logic key_wr_d1;
    fid_t key_waddr_d1;
    flow_key_t key_wdata_d1;

    logic etime_wr;
    fid_t etime_waddr;
    etime_t etime_wdata;

    logic key_ram_wr;
    fid_t key_ram_waddr;
    flow_key_t key_ram_din;
    logic etime_ram_wr;
    fid_t etime_ram_waddr;
    etime_t etime_ram_din;

    // a registered refresh holds the expiry write port, the queue waits
    assign upd.take = upd.valid && !hit_valid_d1 && upd_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            hit_valid_d1 <= 1'b0;
            key_wr_d1 <= 1'b0;
            etime_wr <= 1'b0;
            key_ack <= 1'b0;
            etime_ack <= 1'b0;
        end else begin
            hit_valid_d1 <= hit_valid;
            key_wr_d1 <= key_wr;
            etime_wr <= upd_en && (hit_valid_d1 || upd.valid);
            key_ack <= key_rd;
            etime_ack <= etime_rd;
        end
    end

    always_ff @(posedge clk) begin
        hit_fid_d1 <= hit_fid;
        // time stamp taken together with the hit
        hit_time_d1 <= current_time;
        key_waddr_d1 <= key_waddr;
        key_wdata_d1 <= key_wdata;
        etime_waddr <= hit_valid_d1 ? hit_fid_d1 : upd.fid;
        etime_wdata <= hit_valid_d1 ? hit_time_d1 : upd.etime;
    end

    // clearing overrides every other write
    assign key_ram_wr = clear_en || (key_wr_d1 && upd_en);
    assign key_ram_waddr = clear_en ? sweep_addr : key_waddr_d1;
    assign key_ram_din = clear_en ? '0 : key_wdata_d1;

    assign etime_ram_wr = clear_en || etime_wr;
    assign etime_ram_waddr = clear_en ? sweep_addr : etime_waddr;
    assign etime_ram_din = clear_en ? '0 : etime_wdata;

    ram_1r1w #(
        .WIDTH      ($bits(flow_key_t)),
        .DEPTH_NBITS($bits(fid_t))
    ) u_key_ram (
        .clk  (clk),
        .wr   (key_ram_wr),
        .waddr(key_ram_waddr),
        .din  (key_ram_din),
        .raddr(key_raddr),
        .dout (key_rdata)
    );

    ram_1r1w #(
        .WIDTH      ($bits(etime_t)),
        .DEPTH_NBITS($bits(fid_t))
    ) u_etime_ram (
        .clk  (clk),
        .wr   (etime_ram_wr),
        .waddr(etime_ram_waddr),
        .din  (etime_ram_din),
        .raddr(etime_raddr),
        .dout (etime_rdata)
    );

    // a hit blocks the queue head in the following cycle
    assert property (@(posedge clk) disable iff (reset) hit_valid |=> !upd.take);

endmodule

`default_nettype wire

//--- hash_bank_mem.sv
`timescale 1ns/10ps
`default_nettype none

module hash_bank_mem (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       host_sel,
    input  wire flow_table_pkg::bank_addr_t reg_addr,
    input  wire flow_table_pkg::bucket_t    reg_din,
    input  wire logic                       reg_rd,
    input  wire logic                       reg_wr,
    output logic                            host_ack,
    output flow_table_pkg::bucket_t         host_rdata,
    input  wire logic                       app_rd,
    input  wire flow_table_pkg::bank_addr_t app_raddr,
    input  wire logic                       app_wr,
    input  wire flow_table_pkg::bank_addr_t app_waddr,
    input  wire flow_table_pkg::bucket_t    app_wdata,
    output logic                            app_ack,
    output flow_table_pkg::bucket_t         app_rdata
);
    import flow_table_pkg::*;

    logic host_wr;
    logic mem_wr;
    bank_addr_t mem_waddr;
    bucket_t mem_wdata;

    assign host_wr = host_sel && reg_wr;

    // application write owns the write port when both arrive
    assign mem_wr = app_wr || host_wr;
    assign mem_waddr = app_wr ? app_waddr : reg_addr;
    assign mem_wdata = app_wr ? app_wdata : reg_din;

    always_ff @(posedge clk) begin
        if (reset) begin
            host_ack <= 1'b0;
            app_ack <= 1'b0;
        end else begin
            host_ack <= host_sel && (reg_rd || reg_wr);
            app_ack <= app_rd;
        end
    end

    // two copies with one write port give the host its own read port
    ram_1r1w #(
        .WIDTH      ($bits(bucket_t)),
        .DEPTH_NBITS($bits(bank_addr_t))
    ) u_host_ram (
        .clk  (clk),
        .wr   (mem_wr),
        .waddr(mem_waddr),
        .din  (mem_wdata),
        .raddr(reg_addr),
        .dout (host_rdata)
    );

    ram_1r1w #(
        .WIDTH      ($bits(bucket_t)),
        .DEPTH_NBITS($bits(bank_addr_t))
    ) u_app_ram (
        .clk  (clk),
        .wr   (mem_wr),
        .waddr(mem_waddr),
        .din  (mem_wdata),
        .raddr(app_raddr),
        .dout (app_rdata)
    );

endmodule

`default_nettype wire

//--- flow_table_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "flow_table_params.svh"

module flow_table_top (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [`FT_DEPTH_NBITS:0]   reg_addr,
    input  wire flow_table_pkg::bucket_t    reg_din,
    input  wire logic                       reg_rd,
    input  wire logic                       reg_wr,
    output logic                            reg_ack,
    output flow_table_pkg::bucket_t         reg_rdata,
    input  wire logic                       tbl0_rd,
    input  wire flow_table_pkg::bank_addr_t tbl0_raddr,
    input  wire logic                       tbl0_wr,
    input  wire flow_table_pkg::bank_addr_t tbl0_waddr,
    input  wire flow_table_pkg::bucket_t    tbl0_wdata,
    output logic                            tbl0_ack,
    output flow_table_pkg::bucket_t         tbl0_rdata,
    input  wire logic                       tbl1_rd,
    input  wire flow_table_pkg::bank_addr_t tbl1_raddr,
    input  wire logic                       tbl1_wr,
    input  wire flow_table_pkg::bank_addr_t tbl1_waddr,
    input  wire flow_table_pkg::bucket_t    tbl1_wdata,
    output logic                            tbl1_ack,
    output flow_table_pkg::bucket_t         tbl1_rdata,
    input  wire logic                       key_rd,
    input  wire flow_table_pkg::fid_t       key_raddr,
    input  wire logic                       key_wr,
    input  wire flow_table_pkg::fid_t       key_waddr,
    input  wire flow_table_pkg::flow_key_t  key_wdata,
    output logic                            key_ack,
    output flow_table_pkg::flow_key_t       key_rdata,
    input  wire logic                       etime_rd,
    input  wire flow_table_pkg::fid_t       etime_raddr,
    output logic                            etime_ack,
    output flow_table_pkg::etime_t          etime_rdata,
    input  wire flow_table_pkg::etime_t     current_time,
    input  wire logic                       hit_valid,
    input  wire flow_table_pkg::fid_t       hit_fid,
    input  wire logic                       new_flow_valid,
    input  wire flow_table_pkg::fid_t       new_flow_fid,
    input  wire flow_table_pkg::etime_t     new_flow_etime,
    output logic                            new_flow_credit,
    output logic                            ready
);
    import flow_table_pkg::*;

    logic clear_en;
    logic upd_en;
    logic sweep_last;
    fid_t sweep_addr;

    logic bank_sel;
    logic bank_sel_q;
    logic host_ack0;
    logic host_ack1;
    bucket_t host_rdata0;
    bucket_t host_rdata1;

    etime_upd_if upd_bus ();

    init_ctrl u_init_ctrl (
        .clk       (clk),
        .reset     (reset),
        .sweep_last(sweep_last),
        .clear_en  (clear_en),
        .upd_en    (upd_en),
        .ready     (ready)
    );

    sweep_counter u_sweep_counter (
        .clk       (clk),
        .reset     (reset),
        .clear_en  (clear_en),
        .sweep_addr(sweep_addr),
        .sweep_last(sweep_last)
    );

    etime_upd_fifo u_etime_upd_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (new_flow_valid),
        .push_fid  (new_flow_fid),
        .push_etime(new_flow_etime),
        .credit    (new_flow_credit),
        .upd       (upd_bus.src)
    );

    flow_value_mem u_flow_value_mem (
        .clk         (clk),
        .reset       (reset),
        .clear_en    (clear_en),
        .upd_en      (upd_en),
        .sweep_addr  (sweep_addr),
        .current_time(current_time),
        .hit_valid   (hit_valid),
        .hit_fid     (hit_fid),
        .key_rd      (key_rd),
        .key_raddr   (key_raddr),
        .key_wr      (key_wr),
        .key_waddr   (key_waddr),
        .key_wdata   (key_wdata),
        .key_ack     (key_ack),
        .key_rdata   (key_rdata),
        .etime_rd    (etime_rd),
        .etime_raddr (etime_raddr),
        .etime_ack   (etime_ack),
        .etime_rdata (etime_rdata),
        .upd         (upd_bus.snk)
    );

    // top address bit picks the bank
    assign bank_sel = reg_addr[`FT_DEPTH_NBITS];

    hash_bank_mem u_bank0 (
        .clk       (clk),
        .reset     (reset),
        .host_sel  (!bank_sel),
        .reg_addr  (reg_addr[`FT_DEPTH_NBITS-1:0]),
        .reg_din   (reg_din),
        .reg_rd    (reg_rd),
        .reg_wr    (reg_wr),
        .host_ack  (host_ack0),
        .host_rdata(host_rdata0),
        .app_rd    (tbl0_rd),
        .app_raddr (tbl0_raddr),
        .app_wr    (tbl0_wr),
        .app_waddr (tbl0_waddr),
        .app_wdata (tbl0_wdata),
        .app_ack   (tbl0_ack),
        .app_rdata (tbl0_rdata)
    );

    hash_bank_mem u_bank1 (
        .clk       (clk),
        .reset     (reset),
        .host_sel  (bank_sel),
        .reg_addr  (reg_addr[`FT_DEPTH_NBITS-1:0]),
        .reg_din   (reg_din),
        .reg_rd    (reg_rd),
        .reg_wr    (reg_wr),
        .host_ack  (host_ack1),
        .host_rdata(host_rdata1),
        .app_rd    (tbl1_rd),
        .app_raddr (tbl1_raddr),
        .app_wr    (tbl1_wr),
        .app_waddr (tbl1_waddr),
        .app_wdata (tbl1_wdata),
        .app_ack   (tbl1_ack),
        .app_rdata (tbl1_rdata)
    );

    // select follows the access into the ack cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            bank_sel_q <= 1'b0;
        end else if (reg_rd || reg_wr) begin
            bank_sel_q <= bank_sel;
        end
    end

    assign reg_ack = bank_sel_q ? host_ack1 : host_ack0;
    assign reg_rdata = bank_sel_q ? host_rdata1 : host_rdata0;

endmodule

`default_nettype wire

//--- tb_flow_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "flow_table_params.svh"

module tb_flow_table;
    import flow_table_pkg::*;

    localparam int NUM_FLOWS = 1 << `FT_VALUE_DEPTH_NBITS;
    localparam int NUM_BUCKETS = 2 << `FT_DEPTH_NBITS;

    typedef logic [`FT_DEPTH_NBITS:0] host_addr_t;

    typedef enum int {
        HOST_WR, HOST_RD, APP_WR, APP_RD, KEY_WR, KEY_RD,
        ETIME_RD, HIT, NEW_FLOW, HIT_NEW, DRAIN
    } op_e;

    typedef struct {
        op_e op;
        host_addr_t addr;
        logic [63:0] data;
        logic [63:0] expected;
    } entry_t;

    logic clk;
    logic reset;
    host_addr_t reg_addr;
    bucket_t reg_din;
    logic reg_rd;
    logic reg_wr;
    logic reg_ack;
    bucket_t reg_rdata;
    logic tbl0_rd;
    bank_addr_t tbl0_raddr;
    logic tbl0_wr;
    bank_addr_t tbl0_waddr;
    bucket_t tbl0_wdata;
    logic tbl0_ack;
    bucket_t tbl0_rdata;
    logic tbl1_rd;
    bank_addr_t tbl1_raddr;
    logic tbl1_wr;
    bank_addr_t tbl1_waddr;
    bucket_t tbl1_wdata;
    logic tbl1_ack;
    bucket_t tbl1_rdata;
    logic key_rd;
    fid_t key_raddr;
    logic key_wr;
    fid_t key_waddr;
    flow_key_t key_wdata;
    logic key_ack;
    flow_key_t key_rdata;
    logic etime_rd;
    fid_t etime_raddr;
    logic etime_ack;
    etime_t etime_rdata;
    etime_t current_time;
    logic hit_valid;
    fid_t hit_fid;
    logic new_flow_valid;
    fid_t new_flow_fid;
    etime_t new_flow_etime;
    logic new_flow_credit;
    logic ready;

    // models, shadows are filled while the table is built
    etime_t etime_model [NUM_FLOWS];
    bucket_t bank_shadow [NUM_BUCKETS];
    flow_key_t key_shadow [NUM_FLOWS];
    entry_t table_q [$];
    fid_t pend_fid [$];
    etime_t pend_etime [$];
    fid_t mon_fid;

    int credits;
    int credit_pulses;
    int flows_sent;
    int errors;
    int checks;
    bit table_built;

    // hits seen one and two cycles ago
    logic h1_valid = 1'b0;
    logic h2_valid = 1'b0;
    fid_t h1_fid;
    fid_t h2_fid;
    etime_t h1_time;
    etime_t h2_time;

    flow_table_top DUT (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic init_inputs();
        reset = 1'b1;
        reg_addr = '0;
        reg_din = '0;
        reg_rd = 1'b0;
        reg_wr = 1'b0;
        {tbl0_rd, tbl0_raddr, tbl0_wr, tbl0_waddr, tbl0_wdata} = '0;
        {tbl1_rd, tbl1_raddr, tbl1_wr, tbl1_waddr, tbl1_wdata} = '0;
        {key_rd, key_raddr, key_wr, key_waddr, key_wdata} = '0;
        {etime_rd, etime_raddr} = '0;
        {current_time, hit_valid, hit_fid} = '0;
        {new_flow_valid, new_flow_fid, new_flow_etime} = '0;
        credits = `FT_FIFO_DEPTH;
        for (int i = 0; i < NUM_FLOWS; i++) begin
            etime_model[i] = '0;
            key_shadow[i] = '0;
        end
    endtask

    task automatic add_entry(input op_e op, input host_addr_t addr, input logic [63:0] data);
        entry_t e;
        e.op = op;
        e.addr = addr;
        e.data = data;
        e.expected = '0;
        case (op)
            HOST_WR, APP_WR: bank_shadow[addr] = data[`FT_BUCKET_NBITS-1:0];
            HOST_RD, APP_RD: e.expected = 64'(bank_shadow[addr]);
            KEY_WR: key_shadow[fid_t'(addr)] = data[`FT_KEY_NBITS-1:0];
            KEY_RD: e.expected = 64'(key_shadow[fid_t'(addr)]);
            default: ;
        endcase
        table_q.push_back(e);
    endtask

    task automatic build_table();
        bank_addr_t idx;
        fid_t fid;
        logic bank;
        for (int i = 0; i < 4; i++) begin
            idx = bank_addr_t'($urandom_range(NUM_BUCKETS / 2 - 1, 0));
            add_entry(HOST_WR, {1'b0, idx}, 64'($urandom));
            add_entry(HOST_WR, {1'b1, idx}, 64'($urandom));
            add_entry(HOST_RD, {1'b0, idx}, '0);
            add_entry(HOST_RD, {1'b1, idx}, '0);
            add_entry(APP_RD, {1'b0, idx}, '0);
            add_entry(APP_RD, {1'b1, idx}, '0);
            bank = 1'($urandom_range(1, 0));
            add_entry(APP_WR, {bank, idx}, 64'($urandom));
            add_entry(HOST_RD, {bank, idx}, '0);
        end
        for (int i = 0; i < 4; i++) begin
            fid = fid_t'($urandom_range(NUM_FLOWS - 1, 0));
            add_entry(KEY_WR, host_addr_t'(fid), {$urandom, $urandom});
            add_entry(KEY_RD, host_addr_t'(fid), '0);
        end
        // more flows than credits, with hits mixed in
        for (int i = 0; i < 6; i++) begin
            add_entry(NEW_FLOW, host_addr_t'($urandom_range(NUM_FLOWS - 1, 0)), 64'($urandom));
            if (i % 2 == 1) begin
                add_entry(HIT, host_addr_t'($urandom_range(NUM_FLOWS - 1, 0)), 64'($urandom));
            end
        end
        // back-to-back hits stall the queue until the credits run out
        for (int i = 0; i < 6; i++) begin
            add_entry(HIT_NEW, host_addr_t'($urandom_range(NUM_FLOWS - 1, 0)), 64'($urandom));
        end
        add_entry(DRAIN, '0, '0);
        for (int i = 0; i < NUM_FLOWS; i++) begin
            add_entry(ETIME_RD, host_addr_t'(i), '0);
        end
    endtask

    task automatic host_access(input host_addr_t addr, input bucket_t data, input logic wr,
                               input bucket_t exp);
        reg_addr = addr;
        reg_din = data;
        reg_wr = wr;
        reg_rd = !wr;
        next_cycle();
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        check_value("reg_ack", 64'(reg_ack), 64'(1));
        if (!wr) begin
            check_value("reg_rdata", 64'(reg_rdata), 64'(exp));
        end
    endtask

    task automatic app_write(input host_addr_t addr, input bucket_t data);
        if (addr[`FT_DEPTH_NBITS]) begin
            {tbl1_wr, tbl1_waddr, tbl1_wdata} = {1'b1, bank_addr_t'(addr), data};
        end else begin
            {tbl0_wr, tbl0_waddr, tbl0_wdata} = {1'b1, bank_addr_t'(addr), data};
        end
        next_cycle();
        tbl0_wr = 1'b0;
        tbl1_wr = 1'b0;
    endtask

    task automatic app_read(input host_addr_t addr, input bucket_t exp);
        tbl0_raddr = bank_addr_t'(addr);
        tbl1_raddr = bank_addr_t'(addr);
        tbl0_rd = !addr[`FT_DEPTH_NBITS];
        tbl1_rd = addr[`FT_DEPTH_NBITS];
        next_cycle();
        tbl0_rd = 1'b0;
        tbl1_rd = 1'b0;
        if (addr[`FT_DEPTH_NBITS]) begin
            check_value("tbl1_ack", 64'(tbl1_ack), 64'(1));
            check_value("tbl1_rdata", 64'(tbl1_rdata), 64'(exp));
        end else begin
            check_value("tbl0_ack", 64'(tbl0_ack), 64'(1));
            check_value("tbl0_rdata", 64'(tbl0_rdata), 64'(exp));
        end
    endtask

    task automatic key_write(input fid_t fid, input flow_key_t key);
        key_waddr = fid;
        key_wdata = key;
        key_wr = 1'b1;
        next_cycle();
        key_wr = 1'b0;
        repeat (2) next_cycle();
    endtask

    task automatic key_read(input fid_t fid, input flow_key_t exp);
        key_raddr = fid;
        key_rd = 1'b1;
        next_cycle();
        key_rd = 1'b0;
        check_value("key_ack", 64'(key_ack), 64'(1));
        check_value("key_rdata", 64'(key_rdata), 64'(exp));
    endtask

    task automatic etime_read(input fid_t fid, input etime_t exp);
        etime_raddr = fid;
        etime_rd = 1'b1;
        next_cycle();
        etime_rd = 1'b0;
        check_value("etime_ack", 64'(etime_ack), 64'(1));
        check_value("etime_rdata", 64'(etime_rdata), 64'(exp));
    endtask

    // a new flow waits for a credit, the hit goes out in the same cycle
    task automatic send_update(input fid_t fid, input logic [31:0] data, input logic flow,
                               input logic hit);
        while (flow && credits == 0) begin
            next_cycle();
        end
        if (flow) begin
            {new_flow_valid, new_flow_fid, new_flow_etime} = {1'b1, fid, data[31:16]};
            credits--;
            flows_sent++;
            pend_fid.push_back(fid);
            pend_etime.push_back(data[31:16]);
        end
        if (hit) begin
            {hit_valid, hit_fid, current_time} = {1'b1, fid, data[15:0]};
        end
        next_cycle();
        new_flow_valid = 1'b0;
        hit_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((pend_fid.size() != 0 || h1_valid || h2_valid) && n < 200) begin
            next_cycle();
            n++;
        end
        if (n == 200) begin
            errors++;
            $display("new-flow queue did not drain at %0t", $time);
        end
        next_cycle();
        check_value("credits", 64'(credits), 64'(`FT_FIFO_DEPTH));
        check_value("credit_pulses", 64'(credit_pulses), 64'(flows_sent));
    endtask

    // reset, wait out the clear sweep and read every entry back as zero
    task automatic reset_and_clear();
        int n;
        reset = 1'b1;
        repeat (16) next_cycle();
        reset = 1'b0;
        check_value("ready", 64'(ready), 64'(0));
        check_value("acks", 64'({reg_ack, tbl0_ack, tbl1_ack, key_ack, etime_ack}), 64'(0));
        check_value("new_flow_credit", 64'(new_flow_credit), 64'(0));
        n = 0;
        while (!ready && n < NUM_FLOWS + 8) begin
            next_cycle();
            n++;
        end
        if (!ready) begin
            errors++;
            $display("ready did not rise after the clear");
        end else begin
            for (int i = 0; i < NUM_FLOWS; i++) begin
                key_read(fid_t'(i), '0);
                etime_read(fid_t'(i), '0);
            end
        end
    endtask

    task automatic run_table();
        entry_t e;
        foreach (table_q[i]) begin
            e = table_q[i];
            case (e.op)
                HOST_WR: host_access(e.addr, bucket_t'(e.data), 1'b1, '0);
                HOST_RD: host_access(e.addr, '0, 1'b0, bucket_t'(e.expected));
                APP_WR: app_write(e.addr, bucket_t'(e.data));
                APP_RD: app_read(e.addr, bucket_t'(e.expected));
                KEY_WR: key_write(fid_t'(e.addr), flow_key_t'(e.data));
                KEY_RD: key_read(fid_t'(e.addr), flow_key_t'(e.expected));
                ETIME_RD: etime_read(fid_t'(e.addr), etime_model[fid_t'(e.addr)]);
                HIT: send_update(fid_t'(e.addr), e.data[31:0], 1'b0, 1'b1);
                NEW_FLOW: send_update(fid_t'(e.addr), e.data[31:0], 1'b1, 1'b0);
                HIT_NEW: send_update(fid_t'(e.addr), e.data[31:0], 1'b1, 1'b1);
                default: drain();
            endcase
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // expiry writes in landing order: a hit lands three edges after it is
    // driven, a queue entry on the edge after its credit pulse
    always @(negedge clk) begin
        if (h2_valid) begin
            etime_model[h2_fid] = h2_time;
        end
        {h2_valid, h2_fid, h2_time} = {h1_valid, h1_fid, h1_time};
        {h1_valid, h1_fid, h1_time} = {hit_valid, hit_fid, current_time};
        if (new_flow_credit) begin
            credit_pulses++;
            credits++;
            if (pend_fid.size() == 0) begin
                errors++;
                $display("credit pulse with no new flow outstanding at %0t", $time);
            end else begin
                mon_fid = pend_fid.pop_front();
                etime_model[mon_fid] = pend_etime.pop_front();
            end
            if (credits > `FT_FIFO_DEPTH) begin
                errors++;
                $display("more credits returned than the queue holds at %0t", $time);
            end
        end
    end

    initial begin
        wait (table_built);
        // 20 cycles per table entry, plus two rounds of reset, clear and zero check
        repeat (table_q.size() * 20 + 2 * (16 + NUM_FLOWS * 6 + 20)) @(posedge clk);
        $display("watchdog expired before the test sequence finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        init_inputs();
        void'($urandom(89));
        build_table();
        table_built = 1'b1;
        reset_and_clear();
        if (ready) begin
            run_table();
            // second clear wipes the keys and expiry times left by the table
            reset_and_clear();
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- flow_table_top.f
+incdir+.
flow_table_pkg.sv
etime_upd_if.sv
ram_1r1w.sv
init_ctrl.sv
sweep_counter.sv
etime_upd_fifo.sv
flow_value_mem.sv
hash_bank_mem.sv
flow_table_top.sv
tb_flow_table.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_flow_table \
    -f flow_table_top.f \
    -o tb_flow_table

./obj_dir/tb_flow_table > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
